// File: Bender.yml
package:
  name: tiny_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/tiny_isa_pkg.sv
      - verilog/tiny_bus_pkg.sv
      - verilog/tiny_fetch.sv
      - verilog/tiny_exec.sv
      - verilog/tiny_lsu.sv
      - verilog/tiny_core_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/tiny_core_tb.sv

// File: bench/tiny_core_tb.sv
/*
 * Testbench for tiny_core: instruction and data memories answer both buses
 * with random delays, retirements and final data memory checked against a trace
 */

`timescale 1ns/1ns
`include "tiny_core_config.svh"

module tiny_core_tb;
  import tiny_bus_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int RETIRE_WAIT = 100;
  localparam int MEM_WORDS   = 256;

  logic                  clk;
  logic                  rst;
  logic                  fetch_enable;
  logic                  instr_req, instr_gnt, instr_rvalid;
  logic [`TINY_XLEN-1:0] instr_addr, instr_rdata;
  logic                  data_req, data_gnt, data_rvalid;
  mem_req_t              data_bus;
  logic [`TINY_XLEN-1:0] data_rdata;
  logic                  retire_valid;
  retire_t               retire;

  logic [31:0] imem [MEM_WORDS];
  logic [31:0] dmem [MEM_WORDS];
  retire_t     exp_ret [64];
  logic [31:0] exp_addr [16];
  logic [31:0] exp_word [16];
  int          num_ret;
  int          num_words;
  integer      seed;

  // Responder state per bus: 0 idle, 1 before grant, 2 before response
  int          i_phase, i_cnt, d_phase, d_cnt;
  logic [31:0] i_addr_q;
  mem_req_t    d_req_q;

  tiny_core_top UUT (
    .clk_i          (clk),
    .rst_i          (rst),
    .fetch_enable_i (fetch_enable),
    .instr_req_o    (instr_req),
    .instr_gnt_i    (instr_gnt),
    .instr_rvalid_i (instr_rvalid),
    .instr_addr_o   (instr_addr),
    .instr_rdata_i  (instr_rdata),
    .data_req_o     (data_req),
    .data_gnt_i     (data_gnt),
    .data_rvalid_i  (data_rvalid),
    .data_o         (data_bus),
    .data_rdata_i   (data_rdata),
    .retire_valid_o (retire_valid),
    .retire_o       (retire)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  function automatic int random_delay();
    random_delay = $unsigned($random(seed)) % 4;
  endfunction

  task automatic load_trace();
    integer           fd;
    integer           n;
    logic [8*16-1:0]  tok;
    logic [8*256-1:0] skip;
    logic [31:0]      v0, v1, v2, v3, v4, v5, v6;
    fd = $fopen("bench/tiny_core_trace.txt", "r");
    if (fd == 0) begin
      report_failure("Cannot open bench/tiny_core_trace.txt");
    end
    num_ret   = 0;
    num_words = 0;
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok == "#") begin
        n = $fgets(skip, fd);
      end else if (tok == "I") begin
        n = $fscanf(fd, "%h %h", v0, v1);
        if (n != 2) begin
          report_failure("Malformed I line in the trace file");
        end
        imem[v0[9:2]] = v1;
      end else if (tok == "D") begin
        n = $fscanf(fd, "%h %h", v0, v1);
        if (n != 2) begin
          report_failure("Malformed D line in the trace file");
        end
        dmem[v0[9:2]] = v1;
      end else if (tok == "E") begin
        n = $fscanf(fd, "%h %h", v0, v1);
        if (n != 2) begin
          report_failure("Malformed E line in the trace file");
        end
        exp_addr[num_words] = v0;
        exp_word[num_words] = v1;
        num_words++;
      end else if (tok == "R") begin
        n = $fscanf(fd, "%h %h %h %h %h %h %h", v0, v1, v2, v3, v4, v5, v6);
        if (n != 7) begin
          report_failure("Malformed R line in the trace file");
        end
        exp_ret[num_ret]          = '0;
        exp_ret[num_ret].order    = v0;
        exp_ret[num_ret].pc       = v1;
        exp_ret[num_ret].rd_addr  = v2[4:0];
        exp_ret[num_ret].rd_wdata = v3;
        exp_ret[num_ret].trap     = v4[0];
        exp_ret[num_ret].mem_addr = v5;
        exp_ret[num_ret].mem_we   = v6[0];
        num_ret++;
      end else begin
        report_failure("Unknown line tag in the trace file");
      end
    end
    $fclose(fd);
  endtask

  // Grant 0 to 3 cycles after req, response 1 to 4 cycles after grant
  task automatic serve_instr_bus();
    instr_gnt    = 1'b0;
    instr_rvalid = 1'b0;
    if (i_phase == 2) begin
      if (i_cnt == 0) begin
        instr_rvalid = 1'b1;
        instr_rdata  = imem[i_addr_q[9:2]];
        i_phase      = 0;
      end else begin
        i_cnt--;
      end
    end else if (instr_req) begin
      if (i_phase == 0) begin
        i_cnt   = random_delay();
        i_phase = 1;
      end
      if (i_cnt == 0) begin
        instr_gnt = 1'b1;
        i_addr_q  = instr_addr;
        i_cnt     = random_delay();
        i_phase   = 2;
      end else begin
        i_cnt--;
      end
    end
  endtask

  task automatic serve_data_bus();
    data_gnt    = 1'b0;
    data_rvalid = 1'b0;
    if (d_phase == 2) begin
      if (d_cnt == 0) begin
        data_rvalid = 1'b1;
        data_rdata  = dmem[d_req_q.addr[9:2]];
        // Store lands in the memory model with the response
        if (d_req_q.we) begin
          dmem[d_req_q.addr[9:2]] = d_req_q.wdata;
        end
        d_phase = 0;
      end else begin
        d_cnt--;
      end
    end else if (data_req) begin
      if (d_phase == 0) begin
        d_cnt   = random_delay();
        d_phase = 1;
      end
      if (d_cnt == 0) begin
        data_gnt = 1'b1;
        d_req_q  = data_bus;
        // Word accesses only, all byte lanes enabled
        check_field("data_o.be", 32'h0000_000f, data_bus.be);
        d_cnt    = random_delay();
        d_phase  = 2;
      end else begin
        d_cnt--;
      end
    end
  endtask

  // Both buses served from one process, so the random sequence is fixed
  initial begin
    i_phase = 0;
    i_cnt   = 0;
    d_phase = 0;
    d_cnt   = 0;
    forever begin
      @(posedge clk);
      #1;
      serve_instr_bus();
      serve_data_bus();
    end
  end

  task automatic check_field(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (exp === act)
      else report_failure($sformatf("MISMATCH at %0t ns: %s expected %h actual %h",
                                    $time, name, exp, act));
  endtask

  task automatic check_retire(input int idx);
    retire_t e;
    e = exp_ret[idx];
    check_field("retire_o.order", e.order, retire.order);
    check_field("retire_o.pc", e.pc, retire.pc);
    // Retired word is the program word at that pc
    check_field("retire_o.insn", imem[e.pc[9:2]], retire.insn);
    check_field("retire_o.rd_addr", e.rd_addr, retire.rd_addr);
    check_field("retire_o.rd_wdata", e.rd_wdata, retire.rd_wdata);
    check_field("retire_o.trap", e.trap, retire.trap);
    check_field("retire_o.mem_addr", e.mem_addr, retire.mem_addr);
    check_field("retire_o.mem_we", e.mem_we, retire.mem_we);
  endtask

  task automatic wait_retire();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!retire_valid) begin
      cycles++;
      if (cycles > RETIRE_WAIT) begin
        report_failure("Timeout: the core retired no instruction");
      end
      @(negedge clk);
    end
  endtask

  initial begin
    seed         = 23;
    rst          = 1'b1;
    fetch_enable = 1'b0;
    instr_gnt    = 1'b0;
    instr_rvalid = 1'b0;
    instr_rdata  = '0;
    data_gnt     = 1'b0;
    data_rvalid  = 1'b0;
    data_rdata   = '0;
    // Unused instruction words decode as illegal
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = ((i * 4) << 7) | 32'h7f;
      dmem[i] = 32'h5a00_0000 | (i * 4);
    end
    load_trace();
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;

    // Fetch must stay quiet while disabled
    for (int c = 0; c < 20; c++) begin
      @(negedge clk);
      assert (!instr_req)
        else report_failure("Instruction fetch started while fetch_enable_i was low");
    end
    @(posedge clk);
    #1 fetch_enable = 1'b1;

    for (int k = 0; k < num_ret; k++) begin
      wait_retire();
      check_retire(k);
    end
    @(posedge clk);
    #1 fetch_enable = 1'b0;

    for (int k = 0; k < num_words; k++) begin
      check_field($sformatf("dmem[%h]", exp_addr[k]), exp_word[k], dmem[exp_addr[k][9:2]]);
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: bench/tiny_core_trace.txt
# I byte_addr instr_word | D byte_addr data_word | E byte_addr final_data_word (all hex)
# R order pc rd_addr rd_wdata trap mem_addr mem_we (all hex)
I 80 06400093
I 84 FF900113
I 88 002081B3
I 8C 40208233
I 90 0020F2B3
I 94 0020E333
I 98 0020C3B3
I 9C ABCDE437
I A0 00500013
I A4 00100533
I A8 20000493
I AC 0004A583
I B0 0044A603
I B4 0084A423
I B8 0084A683
I BC 00A08463
I C0 00100713
I C4 00A09463
I C8 00208463
I CC 00209463
I D0 00200713
I D4 00C007EF
I D8 00300713
I DC 00400713
I E0 FFFFFFFF
I E4 0034A623
I E8 0000006F
D 200 12345678
D 204 CAFEF00D
R 0 80 1 00000064 0 0 0
R 1 84 2 FFFFFFF9 0 0 0
R 2 88 3 0000005D 0 0 0
R 3 8C 4 0000006B 0 0 0
R 4 90 5 00000060 0 0 0
R 5 94 6 FFFFFFFD 0 0 0
R 6 98 7 FFFFFF9D 0 0 0
R 7 9C 8 ABCDE000 0 0 0
R 8 A0 0 00000000 0 0 0
R 9 A4 a 00000064 0 0 0
R a A8 9 00000200 0 0 0
R b AC b 12345678 0 200 0
R c B0 c CAFEF00D 0 204 0
R d B4 0 00000000 0 208 1
R e B8 d ABCDE000 0 208 0
R f BC 0 00000000 0 0 0
R 10 C4 0 00000000 0 0 0
R 11 C8 0 00000000 0 0 0
R 12 CC 0 00000000 0 0 0
R 13 D4 f 000000D8 0 0 0
R 14 E0 0 00000000 1 0 0
R 15 E4 0 00000000 0 20C 1
R 16 E8 0 00000000 0 0 0
R 17 E8 0 00000000 0 0 0
E 200 12345678
E 204 CAFEF00D
E 208 ABCDE000
E 20C 0000005D

// File: tiny_core.f
+incdir+verilog
verilog/tiny_isa_pkg.sv
verilog/tiny_bus_pkg.sv
verilog/tiny_fetch.sv
verilog/tiny_exec.sv
verilog/tiny_lsu.sv
verilog/tiny_core_top.sv
bench/tiny_core_tb.sv

// File: verilog/tiny_bus_pkg.sv
/*
 * Bus and trace types for tiny_core: memory request and retirement record
 */

`include "tiny_core_config.svh"

package tiny_bus_pkg;

  // Request phase payload, held stable while req is high
  typedef struct packed {
    logic [`TINY_XLEN-1:0]   addr;
    logic                    we;
    logic [`TINY_XLEN/8-1:0] be;
    logic [`TINY_XLEN-1:0]   wdata;
  } mem_req_t;

  // One record per retired instruction
  typedef struct packed {
    logic [31:0]             order;
    logic [`TINY_XLEN-1:0]   pc;
    logic [31:0]             insn;
    logic                    trap;
    tiny_isa_pkg::reg_addr_t rd_addr;
    logic [`TINY_XLEN-1:0]   rd_wdata;
    logic [`TINY_XLEN-1:0]   mem_addr;
    logic                    mem_we;
  } retire_t;

endpackage

// File: verilog/tiny_core_config.svh
/*
 * Build-time configuration of the tiny_core RV32I subset core
 */

`ifndef TINY_CORE_CONFIG_SVH
`define TINY_CORE_CONFIG_SVH

// Program counter value after reset
`define TINY_BOOT_ADDR 32'h0000_0080

// Data, address and bus width
`define TINY_XLEN 32

// Integer register file size, x0 reads as zero
`define TINY_NUM_REGS 32

`endif

// File: verilog/tiny_core_top.sv
/*
 * tiny_core top level: fetch, execute and load/store unit
 * with separate instruction and data buses and a retirement trace
 */

`timescale 1ns/1ns
`include "tiny_core_config.svh"

module tiny_core_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   fetch_enable_i,
  output logic                   instr_req_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  output logic [`TINY_XLEN-1:0]  instr_addr_o,
  input  logic [`TINY_XLEN-1:0]  instr_rdata_i,
  output logic                   data_req_o,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  output tiny_bus_pkg::mem_req_t data_o,
  input  logic [`TINY_XLEN-1:0]  data_rdata_i,
  output logic                   retire_valid_o,
  output tiny_bus_pkg::retire_t  retire_o
);
  import tiny_bus_pkg::*;

  logic                  instr_valid;
  logic [`TINY_XLEN-1:0] instr;
  logic [`TINY_XLEN-1:0] instr_pc;
  logic                  pc_load;
  logic [`TINY_XLEN-1:0] pc_target;
  logic                  lsu_start;
  mem_req_t              lsu_req;
  logic                  lsu_done;
  logic [`TINY_XLEN-1:0] lsu_rdata;

  tiny_fetch u_fetch (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .enable_i      (fetch_enable_i),
    .pc_load_i     (pc_load),
    .pc_target_i   (pc_target),
    .req_o         (instr_req_o),
    .gnt_i         (instr_gnt_i),
    .rvalid_i      (instr_rvalid_i),
    .rdata_i       (instr_rdata_i),
    .addr_o        (instr_addr_o),
    .instr_valid_o (instr_valid),
    .instr_o       (instr),
    .pc_o          (instr_pc)
  );

  tiny_exec u_exec (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .pc_i           (instr_pc),
    .pc_load_o      (pc_load),
    .pc_target_o    (pc_target),
    .lsu_start_o    (lsu_start),
    .lsu_req_o      (lsu_req),
    .lsu_done_i     (lsu_done),
    .lsu_rdata_i    (lsu_rdata),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o)
  );

  tiny_lsu u_lsu (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .start_i       (lsu_start),
    .req_i         (lsu_req),
    .done_o        (lsu_done),
    .rdata_o       (lsu_rdata),
    .data_req_o    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .data_o        (data_o)
  );

endmodule

// File: verilog/tiny_exec.sv
/*
 * Decode, register file, ALU, branch resolution and retirement.
 * Loads and stores are handed to the LSU and retire on its done strobe
 */

`timescale 1ns/1ns
`include "tiny_core_config.svh"

module tiny_exec (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   instr_valid_i,
  input  logic [`TINY_XLEN-1:0]  instr_i,
  input  logic [`TINY_XLEN-1:0]  pc_i,
  output logic                   pc_load_o,
  output logic [`TINY_XLEN-1:0]  pc_target_o,
  output logic                   lsu_start_o,
  output tiny_bus_pkg::mem_req_t lsu_req_o,
  input  logic                   lsu_done_i,
  input  logic [`TINY_XLEN-1:0]  lsu_rdata_i,
  output logic                   retire_valid_o,
  output tiny_bus_pkg::retire_t  retire_o
);
  import tiny_isa_pkg::*;
  import tiny_bus_pkg::*;

  decoded_instr_t        dec;
  logic [`TINY_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [`TINY_XLEN-1:0] regs [`TINY_NUM_REGS];
  logic [`TINY_XLEN-1:0] rs1_val, rs2_val, op_b, alu_res;
  logic [`TINY_XLEN-1:0] seq_pc, br_target, wb_val;
  logic                  is_mem, take_target, retire_now;
  logic                  busy_q, retire_valid_q;
  logic [31:0]           order_q;
  retire_t               retire_d, retire_q;
  logic [`TINY_XLEN-1:0] pc_target_d, pc_target_q;
  logic [`TINY_XLEN-1:0] pend_pc, pend_insn, pend_addr;
  reg_addr_t             pend_rd;
  logic                  pend_we;

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  // Anything not matched stays illegal with rd = x0
  always_comb begin
    dec        = '0;
    dec.kind   = KIND_ILLEGAL;
    dec.alu_op = ALU_ADD;
    dec.rs1    = instr_i[19:15];
    dec.rs2    = instr_i[24:20];
    case (instr_i[6:0])
      OPC_OP_IMM: if (instr_i[14:12] == 3'b000) begin
        dec.kind    = KIND_ALU;
        dec.rd      = instr_i[11:7];
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
      end
      OPC_OP: begin
        dec.kind = KIND_ALU;
        dec.rd   = instr_i[11:7];
        case ({instr_i[31:25], instr_i[14:12]})
          {7'b0000000, 3'b000}: dec.alu_op = ALU_ADD;
          {7'b0100000, 3'b000}: dec.alu_op = ALU_SUB;
          {7'b0000000, 3'b111}: dec.alu_op = ALU_AND;
          {7'b0000000, 3'b110}: dec.alu_op = ALU_OR;
          {7'b0000000, 3'b100}: dec.alu_op = ALU_XOR;
          default: begin
            dec.kind = KIND_ILLEGAL;
            dec.rd   = '0;
          end
        endcase
      end
      OPC_LUI: begin
        dec.kind    = KIND_ALU;
        dec.alu_op  = ALU_PASS;
        dec.rd      = instr_i[11:7];
        dec.imm     = imm_u;
        dec.use_imm = 1'b1;
      end
      OPC_LOAD: if (instr_i[14:12] == 3'b010) begin
        dec.kind = KIND_LOAD;
        dec.rd   = instr_i[11:7];
        dec.imm  = imm_i;
      end
      OPC_STORE: if (instr_i[14:12] == 3'b010) begin
        dec.kind = KIND_STORE;
        dec.imm  = imm_s;
      end
      OPC_BRANCH: if (instr_i[14:13] == 2'b00) begin
        dec.kind  = KIND_BRANCH;
        dec.imm   = imm_b;
        dec.br_eq = ~instr_i[12];
      end
      OPC_JAL: begin
        dec.kind = KIND_JAL;
        dec.rd   = instr_i[11:7];
        dec.imm  = imm_j;
      end
      default: ;
    endcase
  end

  assign rs1_val = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
  assign rs2_val = (dec.rs2 == '0) ? '0 : regs[dec.rs2];
  assign op_b    = dec.use_imm ? dec.imm : rs2_val;

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:  alu_res = rs1_val + op_b;
      ALU_SUB:  alu_res = rs1_val - op_b;
      ALU_AND:  alu_res = rs1_val & op_b;
      ALU_OR:   alu_res = rs1_val | op_b;
      ALU_XOR:  alu_res = rs1_val ^ op_b;
      ALU_PASS: alu_res = op_b;
      default:  alu_res = '0;
    endcase
  end

  assign seq_pc      = pc_i + `TINY_XLEN'(4);
  assign br_target   = pc_i + dec.imm;
  assign take_target = (dec.kind == KIND_JAL) ||
                       ((dec.kind == KIND_BRANCH) && ((rs1_val == rs2_val) == dec.br_eq));
  assign wb_val      = (dec.kind == KIND_JAL) ? seq_pc : alu_res;
  assign is_mem      = (dec.kind == KIND_LOAD) || (dec.kind == KIND_STORE);

  // Word access, address from rs1 + offset
  assign lsu_start_o     = instr_valid_i && is_mem;
  assign lsu_req_o.addr  = rs1_val + dec.imm;
  assign lsu_req_o.we    = (dec.kind == KIND_STORE);
  assign lsu_req_o.be    = '1;
  assign lsu_req_o.wdata = rs2_val;

  assign retire_now = (instr_valid_i && !is_mem) || (busy_q && lsu_done_i);

  always_comb begin
    retire_d.order = order_q;
    if (busy_q) begin
      // Completion of a pending load or store
      retire_d.pc       = pend_pc;
      retire_d.insn     = pend_insn;
      retire_d.trap     = 1'b0;
      retire_d.rd_addr  = pend_rd;
      retire_d.rd_wdata = (pend_rd != '0) ? lsu_rdata_i : '0;
      retire_d.mem_addr = pend_addr;
      retire_d.mem_we   = pend_we;
      pc_target_d       = pend_pc + `TINY_XLEN'(4);
    end else begin
      retire_d.pc       = pc_i;
      retire_d.insn     = instr_i;
      retire_d.trap     = (dec.kind == KIND_ILLEGAL);
      retire_d.rd_addr  = dec.rd;
      retire_d.rd_wdata = (dec.rd != '0) ? wb_val : '0;
      retire_d.mem_addr = '0;
      retire_d.mem_we   = 1'b0;
      pc_target_d       = take_target ? br_target : seq_pc;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q         <= 1'b0;
      retire_valid_q <= 1'b0;
      order_q        <= '0;
    end else begin
      retire_valid_q <= retire_now;
      if (retire_now) begin
        order_q <= order_q + 32'd1;
      end
      if (lsu_start_o) begin
        busy_q <= 1'b1;
      end else if (lsu_done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (retire_now) begin
      retire_q    <= retire_d;
      pc_target_q <= pc_target_d;
      if (retire_d.rd_addr != '0) begin
        regs[retire_d.rd_addr] <= retire_d.rd_wdata;
      end
    end
    if (lsu_start_o) begin
      pend_pc   <= pc_i;
      pend_insn <= instr_i;
      pend_rd   <= dec.rd;
      pend_addr <= lsu_req_o.addr;
      pend_we   <= lsu_req_o.we;
    end
  end

  // Next pc is loaded in the retirement cycle
  assign retire_valid_o = retire_valid_q;
  assign retire_o       = retire_q;
  assign pc_load_o      = retire_valid_q;
  assign pc_target_o    = pc_target_q;

endmodule

// File: verilog/tiny_fetch.sv
/*
 * Instruction fetch: program counter and one-at-a-time fetch on the
 * instruction bus, word handed to execute with its pc
 */

`timescale 1ns/1ns
`include "tiny_core_config.svh"

module tiny_fetch (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  enable_i,
  input  logic                  pc_load_i,
  input  logic [`TINY_XLEN-1:0] pc_target_i,
  output logic                  req_o,
  input  logic                  gnt_i,
  input  logic                  rvalid_i,
  input  logic [`TINY_XLEN-1:0] rdata_i,
  output logic [`TINY_XLEN-1:0] addr_o,
  output logic                  instr_valid_o,
  output logic [`TINY_XLEN-1:0] instr_o,
  output logic [`TINY_XLEN-1:0] pc_o
);

  typedef enum logic [1:0] {F_IDLE, F_REQ, F_WAIT} fetch_state_e;

  fetch_state_e          state_q;
  logic                  pend_q;
  logic [`TINY_XLEN-1:0] pc_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= F_IDLE;
      pend_q  <= 1'b1;
      pc_q    <= `TINY_BOOT_ADDR;
    end else begin
      if (pc_load_i) begin
        pc_q <= pc_target_i;
      end
      case (state_q)
        F_IDLE: begin
          // Fetch is held back here while disabled
          if ((pend_q || pc_load_i) && enable_i) begin
            state_q <= F_REQ;
            pend_q  <= 1'b0;
          end else if (pc_load_i) begin
            pend_q <= 1'b1;
          end
        end
        F_REQ: if (gnt_i) state_q <= F_WAIT;
        F_WAIT: if (rvalid_i) state_q <= F_IDLE;
        default: state_q <= F_IDLE;
      endcase
    end
  end

  assign req_o  = (state_q == F_REQ);
  assign addr_o = pc_q;

  // Word goes to execute in the response cycle
  assign instr_valid_o = (state_q == F_WAIT) && rvalid_i;
  assign instr_o       = rdata_i;
  assign pc_o          = pc_q;

endmodule

// File: verilog/tiny_isa_pkg.sv
/*
 * ISA types for tiny_core: opcodes, ALU operations, decoded instruction
 */

`include "tiny_core_config.svh"

package tiny_isa_pkg;

  typedef logic [$clog2(`TINY_NUM_REGS)-1:0] reg_addr_t;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS
  } alu_op_e;

  typedef enum logic [2:0] {
    KIND_ALU,
    KIND_LOAD,
    KIND_STORE,
    KIND_BRANCH,
    KIND_JAL,
    KIND_ILLEGAL
  } instr_kind_e;

  typedef struct packed {
    instr_kind_e           kind;
    alu_op_e               alu_op;
    reg_addr_t             rd;
    reg_addr_t             rs1;
    reg_addr_t             rs2;
    logic [`TINY_XLEN-1:0] imm;
    logic                  use_imm;
    logic                  br_eq;    // BEQ when set, BNE otherwise
  } decoded_instr_t;

endpackage

// File: verilog/tiny_lsu.sv
/*
 * Load/store unit: one word access at a time on the data bus
 */

`timescale 1ns/1ns
`include "tiny_core_config.svh"

module tiny_lsu (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   start_i,
  input  tiny_bus_pkg::mem_req_t req_i,
  output logic                   done_o,
  output logic [`TINY_XLEN-1:0]  rdata_o,
  output logic                   data_req_o,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  input  logic [`TINY_XLEN-1:0]  data_rdata_i,
  output tiny_bus_pkg::mem_req_t data_o
);
  import tiny_bus_pkg::*;

  typedef enum logic [1:0] {L_IDLE, L_REQ, L_WAIT} lsu_state_e;

  lsu_state_e            state_q;
  logic                  done_q;
  mem_req_t              req_q;
  logic [`TINY_XLEN-1:0] rdata_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= L_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        L_IDLE: if (start_i) state_q <= L_REQ;
        L_REQ: if (data_gnt_i) state_q <= L_WAIT;
        L_WAIT: begin
          if (data_rvalid_i) begin
            state_q <= L_IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= L_IDLE;
      endcase
    end
  end

  // Access held stable until granted
  always_ff @(posedge clk_i) begin
    if (start_i && (state_q == L_IDLE)) begin
      req_q <= req_i;
    end
    if (data_rvalid_i && (state_q == L_WAIT)) begin
      rdata_q <= data_rdata_i;
    end
  end

  assign data_req_o = (state_q == L_REQ);
  assign data_o     = req_q;
  assign done_o     = done_q;
  assign rdata_o    = rdata_q;

endmodule
